//--- source/hmc_init_cfg.svh
`ifndef HMC_INIT_CFG_SVH
`define HMC_INIT_CFG_SVH

// ---------------------------------------------------------
// link bring-up configuration
// ---------------------------------------------------------

// number of controller links, one sequencer and register file each
`define HMC_NUM_LINKS 4
// lanes per link, at most 8 fit the status_init lock field
`define HMC_NUM_LANES 8

// register bus widths
`define HMC_RF_AWIDTH 5
`define HMC_RF_DWIDTH 64

// status reads allowed per poll phase before the link is failed
`define HMC_POLL_LIMIT 64
// idle cycles between start grants, must be 1 or more
`define HMC_RELEASE_GAP 4

`endif

//--- source/hmc_rf_pkg.sv
`include "hmc_init_cfg.svh"

package hmc_rf_pkg;

  // ---------------------------------------------------------
  // register bus
  // ---------------------------------------------------------

  // request from the init sequencer, enables are one-cycle pulses
  typedef struct packed {
    logic                      read_en;
    logic                      write_en;
    logic [`HMC_RF_AWIDTH-1:0] address;
    logic [`HMC_RF_DWIDTH-1:0] write_data;
  } rf_req_t;

  // response one cycle after the request
  typedef struct packed {
    logic                      access_complete;
    logic                      invalid_address;
    logic [`HMC_RF_DWIDTH-1:0] read_data;
  } rf_rsp_t;

  // address map, counters at 0x3 to 0xC read as zero here
  localparam logic [`HMC_RF_AWIDTH-1:0] STATUS_GENERAL_ADDR = 'h0;
  localparam logic [`HMC_RF_AWIDTH-1:0] STATUS_INIT_ADDR    = 'h1;
  localparam logic [`HMC_RF_AWIDTH-1:0] CONTROL_ADDR        = 'h2;
  localparam logic [`HMC_RF_AWIDTH-1:0] LAST_COUNTER_ADDR   = 'hC;

  // ---------------------------------------------------------
  // register layouts
  // ---------------------------------------------------------

  // control register, bit 0 drives the PHY reset
  typedef struct packed {
    logic [18:0] rsvd_63_45;
    logic [4:0]  irtry_hi;
    logic [2:0]  rsvd_39_37;
    logic [4:0]  irtry_lo;
    logic [7:0]  rsvd_31_24;
    logic [7:0]  rx_tokens;
    logic [10:0] rsvd_15_5;
    logic        run_length_enable;
    logic [1:0]  rsvd_3_2;
    logic        init_cont_set;
    logic        p_rst_n;
  } rf_ctrl_t;

  // low byte holds lane locks in status_init and link_up in status_general
  typedef union packed {
    logic [7:0] lane_locked;
    struct packed {
      logic [6:0] rsvd_7_1;
      logic       link_up;
    } general;
  } rf_status_lo_u;

  typedef struct packed {
    logic [14:0]   rsvd_63_49;
    logic          all_aligned;
    logic [39:0]   rsvd_47_8;
    rf_status_lo_u lo;
  } rf_status_t;

  // one bus word, the address picks the view
  typedef union packed {
    rf_ctrl_t                  ctrl;
    rf_status_t                status;
    logic [`HMC_RF_DWIDTH-1:0] raw;
  } rf_word_u;

  // release p_rst_n, 255 tokens, irtry 16 and 24
  localparam rf_ctrl_t CTRL_RELEASE_WORD = '{
    irtry_hi: 5'd24, irtry_lo: 5'd16, rx_tokens: 8'hff,
    run_length_enable: 1'b1, p_rst_n: 1'b1, default: '0
  };
  // same word with the descramblers allowed to lock
  localparam rf_ctrl_t CTRL_INIT_CONT_WORD = '{
    irtry_hi: 5'd24, irtry_lo: 5'd16, rx_tokens: 8'hff,
    run_length_enable: 1'b1, init_cont_set: 1'b1, p_rst_n: 1'b1, default: '0
  };

endpackage

//--- source/hmc_init_pkg.sv
`include "hmc_init_cfg.svh"

package hmc_init_pkg;

  // sequencer states in bring-up order
  typedef enum logic [3:0] {
    ST_RELEASE,
    ST_RELEASE_WAIT,
    ST_WAIT_START,
    ST_CONT_SET,
    ST_CONT_WAIT,
    ST_RD_INIT,
    ST_RD_INIT_WAIT,
    ST_RD_GEN,
    ST_RD_GEN_WAIT,
    ST_DONE,
    ST_ERROR
  } init_state_e;

  // raw PHY status of one link
  typedef struct packed {
    logic [`HMC_NUM_LANES-1:0] lane_locked;
    logic                      aligned;
    logic                      link_up;
  } link_status_t;

  // outcome of one link, both flags sticky
  typedef struct packed {
    logic done;
    logic error;
  } link_result_t;

endpackage

//--- source/hmc_iic_release.sv
`include "hmc_init_cfg.svh"

module hmc_iic_release (
  input  logic                      clk_hmc,
  input  logic                      reset_i,
  input  logic                      iic_init_done_i,
  input  logic [`HMC_NUM_LINKS-1:0] start_ready_i,
  output logic [`HMC_NUM_LINKS-1:0] start_valid_o
);

  localparam int NUM_LINKS = `HMC_NUM_LINKS;
  localparam int GAP       = `HMC_RELEASE_GAP;
  localparam int IDX_W     = (NUM_LINKS > 1) ? $clog2(NUM_LINKS) : 1;
  localparam int GAP_W     = (GAP > 1) ? $clog2(GAP) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_LINKS - 1);

  logic             started_q;
  logic             finished_q;
  logic             offer_q;
  logic [IDX_W-1:0] link_idx_q;
  logic [GAP_W-1:0] gap_cnt_q;
  logic             accepted;

  // grant taken by the link currently offered
  assign accepted = offer_q && start_ready_i[link_idx_q];

  // ---------------------------------------------------------
  // grant sequencing
  // ---------------------------------------------------------
  always_ff @(posedge clk_hmc) begin
    if (reset_i) begin
      started_q  <= 1'b0;
      finished_q <= 1'b0;
      offer_q    <= 1'b0;
      link_idx_q <= '0;
      gap_cnt_q  <= '0;
    end else if (!started_q) begin
      // first offer goes out the cycle after I2C config is done
      if (iic_init_done_i) begin
        started_q <= 1'b1;
        offer_q   <= 1'b1;
      end
    end else if (accepted) begin
      offer_q <= 1'b0;
      if (link_idx_q == LAST_IDX) begin
        finished_q <= 1'b1;
      end else begin
        link_idx_q <= link_idx_q + 1'b1;
        // counts down to zero, giving GAP idle cycles
        gap_cnt_q  <= GAP_W'(GAP - 1);
      end
    end else if (!offer_q && !finished_q) begin
      if (gap_cnt_q == '0) begin
        offer_q <= 1'b1;
      end else begin
        gap_cnt_q <= gap_cnt_q - 1'b1;
      end
    end
  end

  // one-hot valid, held while the link is not ready
  always_comb begin
    for (int i = 0; i < NUM_LINKS; i++) begin
      start_valid_o[i] = offer_q && (link_idx_q == IDX_W'(i));
    end
  end

endmodule

//--- source/hmc_link_init.sv
`include "hmc_init_cfg.svh"

module hmc_link_init (
  input  logic                       clk_hmc,
  input  logic                       reset_i,
  input  logic                       start_valid_i,
  output logic                       start_ready_o,
  output hmc_rf_pkg::rf_req_t        rf_req_o,
  input  hmc_rf_pkg::rf_rsp_t        rf_rsp_i,
  output hmc_init_pkg::link_result_t result_o
);

  localparam int POLL_W = $clog2(`HMC_POLL_LIMIT + 1);

  hmc_init_pkg::init_state_e  state_q;
  hmc_rf_pkg::rf_req_t        req_q;
  hmc_init_pkg::link_result_t result_q;
  logic [POLL_W-1:0]          poll_cnt_q;
  hmc_rf_pkg::rf_word_u       rd_word;
  logic                       rsp_ok;
  logic                       rsp_bad;
  logic                       lanes_ok;
  logic                       link_up;
  logic                       poll_last;

  // read data decoded through the status view
  assign rd_word   = rf_rsp_i.read_data;
  assign lanes_ok  = (&rd_word.status.lo.lane_locked[`HMC_NUM_LANES-1:0])
                     && rd_word.status.all_aligned;
  assign link_up   = rd_word.status.lo.general.link_up;
  assign rsp_ok    = rf_rsp_i.access_complete && !rf_rsp_i.invalid_address;
  assign rsp_bad   = rf_rsp_i.access_complete && rf_rsp_i.invalid_address;
  assign poll_last = (poll_cnt_q == POLL_W'(`HMC_POLL_LIMIT - 1));

  // grant accepted only while parked in the wait state
  assign start_ready_o = (state_q == hmc_init_pkg::ST_WAIT_START);
  assign rf_req_o      = req_q;
  assign result_o      = result_q;

  // ---------------------------------------------------------
  // bring-up FSM
  // ---------------------------------------------------------
  always_ff @(posedge clk_hmc) begin
    if (reset_i) begin
      state_q    <= hmc_init_pkg::ST_RELEASE;
      req_q      <= '0;
      result_q   <= '0;
      poll_cnt_q <= '0;
    end else begin
      // enables are single-cycle pulses
      req_q.read_en  <= 1'b0;
      req_q.write_en <= 1'b0;
      case (state_q)
        // release p_rst_n right after reset
        hmc_init_pkg::ST_RELEASE: begin
          req_q.address    <= hmc_rf_pkg::CONTROL_ADDR;
          req_q.write_data <= hmc_rf_pkg::CTRL_RELEASE_WORD;
          req_q.write_en   <= 1'b1;
          state_q          <= hmc_init_pkg::ST_RELEASE_WAIT;
        end
        hmc_init_pkg::ST_RELEASE_WAIT: begin
          if (rsp_bad) begin
            result_q.error <= 1'b1;
            state_q        <= hmc_init_pkg::ST_ERROR;
          end else if (rsp_ok) begin
            state_q <= hmc_init_pkg::ST_WAIT_START;
          end
        end
        hmc_init_pkg::ST_WAIT_START: begin
          if (start_valid_i && start_ready_o) begin
            state_q <= hmc_init_pkg::ST_CONT_SET;
          end
        end
        // let the descramblers lock
        hmc_init_pkg::ST_CONT_SET: begin
          req_q.address    <= hmc_rf_pkg::CONTROL_ADDR;
          req_q.write_data <= hmc_rf_pkg::CTRL_INIT_CONT_WORD;
          req_q.write_en   <= 1'b1;
          state_q          <= hmc_init_pkg::ST_CONT_WAIT;
        end
        hmc_init_pkg::ST_CONT_WAIT: begin
          if (rsp_bad) begin
            result_q.error <= 1'b1;
            state_q        <= hmc_init_pkg::ST_ERROR;
          end else if (rsp_ok) begin
            poll_cnt_q <= '0;
            state_q    <= hmc_init_pkg::ST_RD_INIT;
          end
        end
        // poll status_init for lock and alignment
        hmc_init_pkg::ST_RD_INIT: begin
          req_q.address <= hmc_rf_pkg::STATUS_INIT_ADDR;
          req_q.read_en <= 1'b1;
          state_q       <= hmc_init_pkg::ST_RD_INIT_WAIT;
        end
        hmc_init_pkg::ST_RD_INIT_WAIT: begin
          if (rsp_bad || (rsp_ok && !lanes_ok && poll_last)) begin
            result_q.error <= 1'b1;
            state_q        <= hmc_init_pkg::ST_ERROR;
          end else if (rsp_ok && lanes_ok) begin
            poll_cnt_q <= '0;
            state_q    <= hmc_init_pkg::ST_RD_GEN;
          end else if (rsp_ok) begin
            poll_cnt_q <= poll_cnt_q + 1'b1;
            state_q    <= hmc_init_pkg::ST_RD_INIT;
          end
        end
        // poll status_general for link_up
        hmc_init_pkg::ST_RD_GEN: begin
          req_q.address <= hmc_rf_pkg::STATUS_GENERAL_ADDR;
          req_q.read_en <= 1'b1;
          state_q       <= hmc_init_pkg::ST_RD_GEN_WAIT;
        end
        hmc_init_pkg::ST_RD_GEN_WAIT: begin
          if (rsp_bad || (rsp_ok && !link_up && poll_last)) begin
            result_q.error <= 1'b1;
            state_q        <= hmc_init_pkg::ST_ERROR;
          end else if (rsp_ok && link_up) begin
            result_q.done <= 1'b1;
            state_q       <= hmc_init_pkg::ST_DONE;
          end else if (rsp_ok) begin
            poll_cnt_q <= poll_cnt_q + 1'b1;
            state_q    <= hmc_init_pkg::ST_RD_GEN;
          end
        end
        // terminal, flags stay until reset
        hmc_init_pkg::ST_DONE, hmc_init_pkg::ST_ERROR: begin
          state_q <= state_q;
        end
        default: begin
          result_q.error <= 1'b1;
          state_q        <= hmc_init_pkg::ST_ERROR;
        end
      endcase
    end
  end

endmodule

//--- source/hmc_link_rf.sv
`include "hmc_init_cfg.svh"

module hmc_link_rf (
  input  logic                       clk_hmc,
  input  logic                       reset_i,
  input  hmc_rf_pkg::rf_req_t        rf_req_i,
  output hmc_rf_pkg::rf_rsp_t        rf_rsp_o,
  input  hmc_init_pkg::link_status_t link_status_i,
  output hmc_rf_pkg::rf_ctrl_t       link_ctrl_o
);

  hmc_rf_pkg::rf_ctrl_t      ctrl_q;
  hmc_rf_pkg::rf_word_u      wr_word;
  hmc_rf_pkg::rf_word_u      gen_word;
  hmc_rf_pkg::rf_word_u      init_word;
  hmc_rf_pkg::rf_word_u      rd_word;
  logic                      access;
  logic                      addr_bad;
  logic                      complete_q;
  logic                      invalid_q;
  logic [`HMC_RF_DWIDTH-1:0] rdata_q;

  assign wr_word  = rf_req_i.write_data;
  assign access   = rf_req_i.read_en || rf_req_i.write_en;
  assign addr_bad = (rf_req_i.address > hmc_rf_pkg::LAST_COUNTER_ADDR);

  // ---------------------------------------------------------
  // status decode
  // ---------------------------------------------------------
  always_comb begin
    // link_up only counts once init_cont_set is written
    gen_word = '0;
    gen_word.status.lo.general.link_up = link_status_i.link_up && ctrl_q.init_cont_set;

    // lanes report nothing while the PHY is held in reset
    init_word = '0;
    if (ctrl_q.p_rst_n) begin
      init_word.status.lo.lane_locked = 8'(link_status_i.lane_locked);
      init_word.status.all_aligned    = link_status_i.aligned;
    end

    // counters and unmapped addresses read as zero
    rd_word = '0;
    case (rf_req_i.address)
      hmc_rf_pkg::STATUS_GENERAL_ADDR: rd_word = gen_word;
      hmc_rf_pkg::STATUS_INIT_ADDR:    rd_word = init_word;
      hmc_rf_pkg::CONTROL_ADDR:        rd_word.ctrl = ctrl_q;
      default:                         rd_word = '0;
    endcase
  end

  // ---------------------------------------------------------
  // control register and response
  // ---------------------------------------------------------
  always_ff @(posedge clk_hmc) begin
    if (reset_i) begin
      ctrl_q     <= '0;
      complete_q <= 1'b0;
      invalid_q  <= 1'b0;
    end else begin
      if (rf_req_i.write_en && (rf_req_i.address == hmc_rf_pkg::CONTROL_ADDR)) begin
        ctrl_q <= wr_word.ctrl;
      end
      // every access answers on the next cycle
      complete_q <= access;
      invalid_q  <= access && addr_bad;
    end
  end

  // status is sampled on the read cycle
  always_ff @(posedge clk_hmc) begin
    if (rf_req_i.read_en) begin
      rdata_q <= rd_word.raw;
    end
  end

  assign rf_rsp_o.access_complete = complete_q;
  assign rf_rsp_o.invalid_address = invalid_q;
  assign rf_rsp_o.read_data       = rdata_q;
  assign link_ctrl_o              = ctrl_q;

endmodule

//--- source/hmc_init_collect.sv
`include "hmc_init_cfg.svh"

module hmc_init_collect (
  input  logic                                     clk_hmc,
  input  logic                                     reset_i,
  input  hmc_init_pkg::link_result_t [`HMC_NUM_LINKS-1:0] result_i,
  output logic                                     all_done_o,
  output logic [`HMC_NUM_LINKS-1:0]                error_mask_o,
  output logic [$clog2(`HMC_NUM_LINKS+1)-1:0]      done_count_o
);

  localparam int NUM_LINKS = `HMC_NUM_LINKS;
  localparam int CNT_W     = $clog2(NUM_LINKS + 1);

  logic [NUM_LINKS-1:0] err_vec;
  logic [NUM_LINKS-1:0] finish_vec;
  logic [CNT_W-1:0]     done_sum;

  // per-link flags and the number of links that came up
  always_comb begin
    done_sum = '0;
    for (int i = 0; i < NUM_LINKS; i++) begin
      err_vec[i]    = result_i[i].error;
      finish_vec[i] = result_i[i].done || result_i[i].error;
      done_sum      = done_sum + CNT_W'(result_i[i].done);
    end
  end

  // ---------------------------------------------------------
  // registered summary
  // ---------------------------------------------------------
  always_ff @(posedge clk_hmc) begin
    if (reset_i) begin
      all_done_o   <= 1'b0;
      error_mask_o <= '0;
      done_count_o <= '0;
    end else begin
      // finished means either up or failed
      all_done_o   <= &finish_vec;
      error_mask_o <= err_vec;
      done_count_o <= done_sum;
    end
  end

endmodule

//--- source/hmc_init_top.sv
`include "hmc_init_cfg.svh"

module hmc_init_top (
  input  logic                                            clk_hmc,
  input  logic                                            reset_i,
  input  logic                                            iic_init_done_i,
  input  hmc_init_pkg::link_status_t [`HMC_NUM_LINKS-1:0] link_status_i,
  output hmc_rf_pkg::rf_ctrl_t [`HMC_NUM_LINKS-1:0]       link_ctrl_o,
  output logic                                            all_done_o,
  output logic [`HMC_NUM_LINKS-1:0]                       error_mask_o,
  output logic [$clog2(`HMC_NUM_LINKS+1)-1:0]             done_count_o
);

  logic [`HMC_NUM_LINKS-1:0]                       start_valid;
  logic [`HMC_NUM_LINKS-1:0]                       start_ready;
  hmc_rf_pkg::rf_req_t [`HMC_NUM_LINKS-1:0]        rf_req;
  hmc_rf_pkg::rf_rsp_t [`HMC_NUM_LINKS-1:0]        rf_rsp;
  hmc_init_pkg::link_result_t [`HMC_NUM_LINKS-1:0] result;

  // start grants in link order after I2C config
  hmc_iic_release u_release (
    .clk_hmc         (clk_hmc),
    .reset_i         (reset_i),
    .iic_init_done_i (iic_init_done_i),
    .start_ready_i   (start_ready),
    .start_valid_o   (start_valid)
  );

  // ---------------------------------------------------------
  // one sequencer and register file per link
  // ---------------------------------------------------------
  for (genvar g = 0; g < `HMC_NUM_LINKS; g++) begin : g_link
    hmc_link_init u_init (
      .clk_hmc       (clk_hmc),
      .reset_i       (reset_i),
      .start_valid_i (start_valid[g]),
      .start_ready_o (start_ready[g]),
      .rf_req_o      (rf_req[g]),
      .rf_rsp_i      (rf_rsp[g]),
      .result_o      (result[g])
    );

    hmc_link_rf u_rf (
      .clk_hmc       (clk_hmc),
      .reset_i       (reset_i),
      .rf_req_i      (rf_req[g]),
      .rf_rsp_o      (rf_rsp[g]),
      .link_status_i (link_status_i[g]),
      .link_ctrl_o   (link_ctrl_o[g])
    );
  end

  // overall done, error mask and count
  hmc_init_collect u_collect (
    .clk_hmc      (clk_hmc),
    .reset_i      (reset_i),
    .result_i     (result),
    .all_done_o   (all_done_o),
    .error_mask_o (error_mask_o),
    .done_count_o (done_count_o)
  );

endmodule

//--- tb/hmc_init_chk.sv
module hmc_init_chk (
  input logic                clk_hmc,
  input logic                reset_i,
  input logic                start_valid_i,
  input logic                start_ready_i,
  input hmc_rf_pkg::rf_req_t rf_req_i,
  input hmc_rf_pkg::rf_rsp_t rf_rsp_i
);

  // assertion failures seen on this link
  int unsigned fail_count = 0;

  logic req;
  logic pending_q;

  assign req = rf_req_i.read_en || rf_req_i.write_en;

  // one register access in flight until access_complete
  always_ff @(posedge clk_hmc) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (req) begin
      pending_q <= 1'b1;
    end else if (rf_rsp_i.access_complete) begin
      pending_q <= 1'b0;
    end
  end

  // ---------------------------------------------------------
  // register bus
  // ---------------------------------------------------------
  a_one_enable: assert property (@(posedge clk_hmc) disable iff (reset_i)
    !(rf_req_i.read_en && rf_req_i.write_en))
    else begin
      $error("read_en and write_en high in the same cycle");
      fail_count++;
    end

  // the next request comes only once access_complete has been seen
  a_no_overlap: assert property (@(posedge clk_hmc) disable iff (reset_i)
    req |-> !pending_q)
    else begin
      $error("new register request before access_complete");
      fail_count++;
    end

  // ---------------------------------------------------------
  // start grant
  // ---------------------------------------------------------
  a_valid_held: assert property (@(posedge clk_hmc) disable iff (reset_i)
    (start_valid_i && !start_ready_i) |=> start_valid_i)
    else begin
      $error("start_valid dropped before the grant was accepted");
      fail_count++;
    end

endmodule

// one checker inside every link sequencer
bind hmc_link_init hmc_init_chk i_chk (
  .clk_hmc       (clk_hmc),
  .reset_i       (reset_i),
  .start_valid_i (start_valid_i),
  .start_ready_i (start_ready_o),
  .rf_req_i      (rf_req_o),
  .rf_rsp_i      (rf_rsp_i)
);

//--- tb/hmc_init_tb.sv
`include "hmc_init_cfg.svh"

module hmc_init_tb;

  localparam int NUM_LINKS      = `HMC_NUM_LINKS;
  localparam int CNT_W          = $clog2(NUM_LINKS + 1);
  localparam int NUM_TESTS      = 8;
  localparam int MID_RESET_TEST = 3;
  localparam int MAX_LOCK       = 30;
  localparam int MAX_UP         = 30;
  localparam int MAX_DELAY      = MAX_LOCK + MAX_UP;
  localparam int MARGIN         = 300;
  localparam int TEST_CYCLES    = NUM_LINKS * MAX_DELAY + `HMC_POLL_LIMIT * 4 + MARGIN;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES;
  localparam int unsigned SEED  = 32'hdd2ecfbc;

  // predicted summary of one test
  typedef struct packed {
    logic [NUM_LINKS-1:0] error_mask;
    logic [CNT_W-1:0]     done_count;
  } expect_t;

  logic                                         clk_hmc;
  logic                                         reset_i;
  logic                                         iic_init_done_i;
  hmc_init_pkg::link_status_t [NUM_LINKS-1:0]   link_status;
  hmc_rf_pkg::rf_ctrl_t [NUM_LINKS-1:0]         link_ctrl;
  logic                                         all_done_o;
  logic [NUM_LINKS-1:0]                         error_mask_o;
  logic [CNT_W-1:0]                             done_count_o;

  // per-link draws and PHY model state
  int                   lock_dly [NUM_LINKS];
  int                   up_dly [NUM_LINKS];
  logic [NUM_LINKS-1:0] never_up;
  int                   phy_cnt [NUM_LINKS];
  time                  cont_time [NUM_LINKS];
  time                  up_time [NUM_LINKS];
  time                  iic_time;
  int unsigned          chk_fails [NUM_LINKS];

  expect_t expected;
  string   cur_name;
  logic    armed;
  int      errors;
  int      checks;

  hmc_init_top i_dut (
    .clk_hmc         (clk_hmc),
    .reset_i         (reset_i),
    .iic_init_done_i (iic_init_done_i),
    .link_status_i   (link_status),
    .link_ctrl_o     (link_ctrl),
    .all_done_o      (all_done_o),
    .error_mask_o    (error_mask_o),
    .done_count_o    (done_count_o)
  );

  // failure counts of the bound protocol checkers
  for (genvar g = 0; g < NUM_LINKS; g++) begin : g_chk
    assign chk_fails[g] = i_dut.g_link[g].u_init.i_chk.fail_count;
  end

  initial clk_hmc = 1'b0;
  always #5 clk_hmc = ~clk_hmc;

  // ---------------------------------------------------------
  // PHY model with delays counted from init_cont_set
  // ---------------------------------------------------------
  always @(posedge clk_hmc) begin
    #1;
    for (int i = 0; i < NUM_LINKS; i++) begin
      if (!link_ctrl[i].init_cont_set) begin
        phy_cnt[i]     = 0;
        link_status[i] = '0;
      end else begin
        if (phy_cnt[i] == 0) begin
          cont_time[i] = $time;
        end
        phy_cnt[i]++;
        // all lanes lock and align together
        if (phy_cnt[i] >= lock_dly[i]) begin
          link_status[i].lane_locked = '1;
          link_status[i].aligned     = 1'b1;
        end
        if (!never_up[i] && !link_status[i].link_up &&
            phy_cnt[i] >= lock_dly[i] + up_dly[i]) begin
          link_status[i].link_up = 1'b1;
          up_time[i]             = $time;
        end
      end
    end
  end

  // a link errs exactly when it never raises link_up
  function automatic expect_t predict(input logic [NUM_LINKS-1:0] down);
    expect_t res;
    res = '0;
    for (int i = 0; i < NUM_LINKS; i++) begin
      if (down[i]) begin
        res.error_mask[i] = 1'b1;
      end else begin
        res.done_count = res.done_count + 1'b1;
      end
    end
    return res;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0: return "all_up";
      1: return "some_down";
      2: return "late_up";
      MID_RESET_TEST: return "mid_reset";
      default: return $sformatf("random_%0d", t);
    endcase
  endfunction

  task automatic compare_value(input string what, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      $display("MISMATCH %s %s expected 0x%0h actual 0x%0h",
               cur_name, what, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic expect_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s: %s", cur_name, msg);
      errors++;
    end
  endtask

  // every output must read zero while held in reset
  task automatic check_cleared(input string when);
    compare_value({"all_done_o ", when}, 64'(1'b0), 64'(all_done_o));
    compare_value({"error_mask_o ", when}, 64'(0), 64'(error_mask_o));
    compare_value({"done_count_o ", when}, 64'(0), 64'(done_count_o));
    for (int i = 0; i < NUM_LINKS; i++) begin
      compare_value($sformatf("link_ctrl_o[%0d] %s", i, when), 64'(0), 64'(link_ctrl[i]));
    end
  endtask

  task automatic draw_links(input int t);
    for (int i = 0; i < NUM_LINKS; i++) begin
      lock_dly[i] = 1 + int'($urandom % MAX_LOCK);
      up_dly[i]   = 1 + int'($urandom % MAX_UP);
      never_up[i] = (($urandom % 4) == 0);
    end
    case (t)
      0: never_up = '0;
      1: never_up[$urandom % NUM_LINKS] = 1'b1;
      2: begin
        // link_up near the top of its range on every link
        never_up = '0;
        for (int i = 0; i < NUM_LINKS; i++) begin
          up_dly[i] = MAX_UP - int'($urandom % 4);
        end
      end
      MID_RESET_TEST: begin
        // link 0 comes up fast while the rest are still polling at the reset
        for (int i = 1; i < NUM_LINKS; i++) begin
          lock_dly[i] = MAX_LOCK;
        end
        lock_dly[0] = 1;
        up_dly[0]   = 1;
        never_up[0] = 1'b0;
      end
      default: ;
    endcase
  endtask

  // ---------------------------------------------------------
  // compare process
  // ---------------------------------------------------------
  task automatic compare_results();
    time last_up;
    last_up = 0;
    compare_value("error_mask_o", 64'(expected.error_mask), 64'(error_mask_o));
    compare_value("done_count_o", 64'(expected.done_count), 64'(done_count_o));
    expect_true(cont_time[0] > iic_time, "link 0 got init_cont_set before I2C config was done");
    for (int i = 1; i < NUM_LINKS; i++) begin
      expect_true(cont_time[i] > cont_time[i-1],
                  $sformatf("link %0d got init_cont_set out of link order", i));
    end
    for (int i = 0; i < NUM_LINKS; i++) begin
      if (!never_up[i]) begin
        expect_true(up_time[i] != 0, $sformatf("link %0d never saw link_up driven", i));
        if (up_time[i] > last_up) begin
          last_up = up_time[i];
        end
      end
    end
    expect_true($time > last_up, "all_done_o rose before the last link_up was driven");
  endtask

  // registered outputs are stable at the falling edge
  initial begin
    forever begin
      @(negedge clk_hmc);
      if (armed && all_done_o) begin
        compare_results();
        armed = 1'b0;
      end
    end
  end

  // ---------------------------------------------------------
  // one test from reset to all_done_o
  // ---------------------------------------------------------
  task automatic run_test(input int t);
    int pre_gap;
    int waited;
    int errs_before;
    errs_before = errors;
    cur_name    = test_name(t);
    draw_links(t);
    expected = predict(never_up);
    @(posedge clk_hmc);
    #1;
    reset_i         = 1'b1;
    iic_init_done_i = 1'b0;
    for (int i = 0; i < NUM_LINKS; i++) begin
      cont_time[i] = 0;
      up_time[i]   = 0;
    end
    // reset held for 8 rising edges
    repeat (7) @(posedge clk_hmc);
    @(negedge clk_hmc);
    check_cleared("in reset");
    @(posedge clk_hmc);
    #1;
    reset_i = 1'b0;
    pre_gap = 4 + int'($urandom % 8);
    repeat (pre_gap) @(posedge clk_hmc);
    @(negedge clk_hmc);
    for (int i = 0; i < NUM_LINKS; i++) begin
      expect_true(link_ctrl[i].p_rst_n && !link_ctrl[i].init_cont_set,
                  $sformatf("link %0d not released with init_cont_set clear", i));
    end
    expect_true(!all_done_o, "all_done_o high before I2C config finished");
    @(posedge clk_hmc);
    #1;
    iic_init_done_i = 1'b1;
    iic_time        = $time;
    if (t == MID_RESET_TEST) begin
      // reset once link 0 is done and the others are still busy
      waited = 0;
      while (done_count_o == '0 && waited < TEST_CYCLES) begin
        @(negedge clk_hmc);
        waited++;
      end
      expect_true(done_count_o != '0, "no link finished before the mid-run reset");
      expect_true(link_ctrl[0].init_cont_set, "link 0 not started before the mid-run reset");
      @(posedge clk_hmc);
      #1;
      reset_i = 1'b1;
      repeat (2) @(posedge clk_hmc);
      @(negedge clk_hmc);
      check_cleared("after mid-run reset");
    end else begin
      armed = 1'b1;
      wait (!armed);
    end
    $display("%-10s finished, %0d errors", cur_name, errors - errs_before);
  endtask

  initial begin
    int unsigned chk_total;
    void'($urandom(SEED));
    reset_i         = 1'b1;
    iic_init_done_i = 1'b0;
    link_status     = '0;
    never_up        = '0;
    armed           = 1'b0;
    errors          = 0;
    checks          = 0;
    iic_time        = 0;
    for (int i = 0; i < NUM_LINKS; i++) begin
      lock_dly[i]  = 1;
      up_dly[i]    = 1;
      phy_cnt[i]   = 0;
      cont_time[i] = 0;
      up_time[i]   = 0;
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    chk_total = 0;
    for (int i = 0; i < NUM_LINKS; i++) begin
      chk_total += chk_fails[i];
    end
    if (chk_total != 0) begin
      $display("%0d protocol assertions fired in the bound checkers", chk_total);
      errors += int'(chk_total);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog sized from the worst test length
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("timeout after %0d cycles, all_done_o never came in %s",
             WATCHDOG_CYCLES, cur_name);
    $display("test failed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
source/hmc_rf_pkg.sv
source/hmc_init_pkg.sv
source/hmc_iic_release.sv
source/hmc_link_init.sv
source/hmc_link_rf.sv
source/hmc_init_collect.sv
source/hmc_init_top.sv
tb/hmc_init_chk.sv
tb/hmc_init_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hmc_init_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
